//--- include/legalizer_macros.svh
/*
 * burst legalizer sizing
 * bus widths, AXI4 burst limits and the page geometry
 * that every legalizer block derives its widths from
 */
`ifndef LEGALIZER_MACROS_SVH
`define LEGALIZER_MACROS_SVH

// byte addresses on both AXI sides
`define LGZ_ADDR_WIDTH 32
// transfer length in bytes
`define LGZ_LEN_WIDTH 32

// data bus and the byte lanes it carries
`define LGZ_DATA_WIDTH 32
`define LGZ_STRB_WIDTH (`LGZ_DATA_WIDTH / 8)
// low address bits that select a byte within a beat
`define LGZ_OFFSET_WIDTH $clog2(`LGZ_STRB_WIDTH)

// AXI4 incremental bursts: 256 beats, never across 4 KiB
`define LGZ_MAX_BEATS 256
`define LGZ_PAGE_LIMIT 4096

// page is whichever limit bites first
`define LGZ_PAGE_SIZE ((`LGZ_MAX_BEATS * `LGZ_STRB_WIDTH > `LGZ_PAGE_LIMIT) ? \
    `LGZ_PAGE_LIMIT : (`LGZ_MAX_BEATS * `LGZ_STRB_WIDTH))
`define LGZ_PAGE_ADDR_WIDTH $clog2(`LGZ_PAGE_SIZE)

// max log2 burst length option, 0 to 7
`define LGZ_LLEN_WIDTH 3

`endif

//--- hw/legalizer_pkg.sv
/*
 * burst legalizer types
 * request, option, per-side state and burst descriptors
 * shared by the legalizer blocks and the testbench
 */
`include "legalizer_macros.svh"

package legalizer_pkg;

    // byte count from zero up to one full page, hence the extra bit
    typedef logic [`LGZ_PAGE_ADDR_WIDTH:0] page_len_t;

    // ------------------------------
    // request side
    // ------------------------------
    // per-transfer options, sampled when the request is taken
    typedef struct packed {
        logic                       decouple_rw;
        // src (read) page reduction
        logic                       src_reduce_len;
        logic [`LGZ_LLEN_WIDTH-1:0] src_max_llen;
        // dst (write) page reduction
        logic                       dst_reduce_len;
        logic [`LGZ_LLEN_WIDTH-1:0] dst_max_llen;
    } xfer_opt_t;

    // one generic 1D transfer
    typedef struct packed {
        logic [`LGZ_LEN_WIDTH-1:0]  length;
        logic [`LGZ_ADDR_WIDTH-1:0] src_addr;
        logic [`LGZ_ADDR_WIDTH-1:0] dst_addr;
        xfer_opt_t                  opt;
    } xfer_req_t;

    // ------------------------------
    // per side
    // ------------------------------
    // what is left of the transfer on one side
    typedef struct packed {
        logic [`LGZ_LEN_WIDTH-1:0]  length;
        logic [`LGZ_ADDR_WIDTH-1:0] addr;
        logic                       valid;
    } side_state_t;

    // AR or AW burst: beat-aligned address, AXI len is beats minus one
    typedef struct packed {
        logic [`LGZ_ADDR_WIDTH-1:0]         addr;
        logic [$clog2(`LGZ_MAX_BEATS)-1:0] len;
    } burst_req_t;

endpackage

//--- hw/page_boundary.sv
/*
 * page boundary check
 * distance in bytes from the current address of one side
 * to the end of its page; the page may be shrunk per
 * request by the reduce_len and max_llen options
 */
`timescale 1ns/100ps
`include "legalizer_macros.svh"

module page_boundary import legalizer_pkg::*; (
    input  logic [`LGZ_ADDR_WIDTH-1:0] addr_i,
    input  logic                       reduce_len_i,
    input  logic [`LGZ_LLEN_WIDTH-1:0] max_llen_i,
    output page_len_t                  bytes_to_pb_o
);

    // room for offset width plus 8 before the cap
    logic [4:0]                      raw_width;
    logic [3:0]                      page_addr_width;
    page_len_t                       page_size;
    logic [`LGZ_PAGE_ADDR_WIDTH-1:0] page_offset;

    // ------------------------------
    // effective page width
    // ------------------------------
    always_comb begin
        // beats per page as log2, either the option or the full 256
        raw_width = 5'(`LGZ_OFFSET_WIDTH) + (reduce_len_i ? 5'(max_llen_i) : 5'd8);
        // never past the protocol page
        if (raw_width > 5'(`LGZ_PAGE_ADDR_WIDTH)) begin
            page_addr_width = 4'(`LGZ_PAGE_ADDR_WIDTH);
        end else begin
            page_addr_width = raw_width[3:0];
        end
    end

    // page size in bytes
    assign page_size = page_len_t'(1) << page_addr_width;

    // ------------------------------
    // offset within the page
    // ------------------------------
    // variable-width slice of the address, done bit by bit
    always_comb begin
        page_offset = '0;
        for (int i = 0; i < `LGZ_PAGE_ADDR_WIDTH; i++) begin
            // bits above the effective width belong to the page number
            page_offset[i] = (page_addr_width > i) ? addr_i[i] : 1'b0;
        end
    end

    // bytes still fitting before the boundary, a full page when aligned
    assign bytes_to_pb_o = page_size - page_len_t'(page_offset);

endmodule

//--- hw/burst_chopper.sv
/*
 * burst chopper
 * holds the remaining part of a transfer for one side and
 * cuts the next burst from it, limited by the bytes that
 * fit before the page boundary; one burst per advance
 */
`timescale 1ns/100ps
`include "legalizer_macros.svh"

module burst_chopper import legalizer_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_i,
    // new transfer for this side
    input  logic                       load_i,
    input  logic [`LGZ_ADDR_WIDTH-1:0] load_addr_i,
    input  logic [`LGZ_LEN_WIDTH-1:0]  load_len_i,
    // step to the next burst
    input  logic                       advance_i,
    input  logic                       kill_i,
    // bytes allowed in this burst
    input  page_len_t                  bytes_possible_i,
    output logic [`LGZ_ADDR_WIDTH-1:0] state_addr_o,
    output logic                       busy_o,
    output logic                       done_o,
    output burst_req_t                 burst_o
);

    side_state_t                      state_d;
    side_state_t                      state_q;
    // bytes carried by the burst now on offer
    page_len_t                        num_bytes;
    logic [`LGZ_OFFSET_WIDTH-1:0]     addr_offset;
    // last byte of the burst counted from the beat-aligned address
    page_len_t                        beat_span;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_d = state_q;
        done_o  = 1'b0;

        if (state_q.length > bytes_possible_i) begin
            // more left than the page allows, cut here
            num_bytes     = bytes_possible_i;
            state_d.length = state_q.length - bytes_possible_i;
            state_d.addr   = state_q.addr + num_bytes;
        end else begin
            // remainder fits, this is the final burst
            // an empty side lands here too and so reads as done
            num_bytes     = state_q.length[`LGZ_PAGE_ADDR_WIDTH:0];
            state_d.valid = 1'b0;
            done_o        = 1'b1;
        end

        // kill drops whatever is left
        if (kill_i) begin
            state_d = '0;
            done_o  = 1'b1;
        end

        // a fresh transfer wins over kill
        if (load_i) begin
            state_d.length = load_len_i;
            state_d.addr   = load_addr_i;
            state_d.valid  = 1'b1;
        end
    end

    // ------------------------------
    // state register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= '0;
        end else if (advance_i || load_i) begin
            // frozen while stalled or flushed
            state_q <= state_d;
        end
    end

    // ------------------------------
    // burst output
    // ------------------------------
    assign addr_offset = state_q.addr[`LGZ_OFFSET_WIDTH-1:0];

    // partial first beat counts as a whole beat
    assign beat_span = num_bytes + page_len_t'(addr_offset) - page_len_t'(1);

    // address with the byte lanes cleared
    assign burst_o.addr = {state_q.addr[`LGZ_ADDR_WIDTH-1:`LGZ_OFFSET_WIDTH],
                           {`LGZ_OFFSET_WIDTH{1'b0}}};
    // AXI len, beats minus one
    assign burst_o.len  = beat_span[`LGZ_OFFSET_WIDTH +: $clog2(`LGZ_MAX_BEATS)];

    assign state_addr_o = state_q.addr;
    assign busy_o       = state_q.valid;

endmodule

//--- hw/legalizer_control.sv
/*
 * legalizer control
 * option register, read/write coupling, flow control
 * and acceptance of the next 1D transfer
 */
`timescale 1ns/100ps

module legalizer_control import legalizer_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    // 1D request
    input  xfer_req_t req_i,
    input  logic      valid_i,
    output logic      ready_o,
    // burst consumers
    input  logic      r_ready_i,
    input  logic      w_ready_i,
    input  logic      flush_i,
    input  logic      kill_i,
    // chopper status
    input  logic      r_done_i,
    input  logic      w_done_i,
    input  logic      r_busy_i,
    input  logic      w_busy_i,
    // page boundary distance per side
    input  page_len_t r_bytes_to_pb_i,
    input  page_len_t w_bytes_to_pb_i,
    output xfer_opt_t opt_o,
    output page_len_t r_bytes_possible_o,
    output page_len_t w_bytes_possible_o,
    output logic      load_o,
    output logic      r_advance_o,
    output logic      w_advance_o,
    output logic      r_valid_o,
    output logic      w_valid_o
);

    xfer_opt_t opt_q;
    page_len_t c_bytes_to_pb;

    // ------------------------------
    // request acceptance
    // ------------------------------
    // next transfer only once both sides are on their final burst
    assign ready_o = r_done_i & w_done_i & r_ready_i & w_ready_i & !flush_i;
    assign load_o  = ready_o & valid_i;

    // options live as long as the transfer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            opt_q <= '0;
        end else if (load_o) begin
            opt_q <= req_i.opt;
        end
    end

    assign opt_o = opt_q;

    // ------------------------------
    // coupling
    // ------------------------------
    // coupled sides cut at whichever boundary comes first
    assign c_bytes_to_pb = (r_bytes_to_pb_i > w_bytes_to_pb_i) ? w_bytes_to_pb_i
                                                               : r_bytes_to_pb_i;

    assign r_bytes_possible_o = opt_q.decouple_rw ? r_bytes_to_pb_i : c_bytes_to_pb;
    assign w_bytes_possible_o = opt_q.decouple_rw ? w_bytes_to_pb_i : c_bytes_to_pb;

    // ------------------------------
    // flow control
    // ------------------------------
    always_comb begin
        if (opt_q.decouple_rw) begin
            // each side runs on its own ready
            r_advance_o = (r_ready_i & !flush_i) | kill_i;
            w_advance_o = (w_ready_i & !flush_i) | kill_i;
            r_valid_o   = r_busy_i & r_ready_i & !flush_i;
            w_valid_o   = w_busy_i & w_ready_i & !flush_i;
        end else begin
            // lock step, both readies needed
            r_advance_o = (r_ready_i & w_ready_i & !flush_i) | kill_i;
            w_advance_o = (r_ready_i & w_ready_i & !flush_i) | kill_i;
            r_valid_o   = r_busy_i & r_ready_i & w_ready_i & !flush_i;
            w_valid_o   = w_busy_i & r_ready_i & w_ready_i & !flush_i;
        end
    end

endmodule

//--- hw/burst_legalizer.sv
/*
 * AXI4 burst legalizer
 * splits one 1D transfer into read and write bursts that
 * stay within a page, coupled or decoupled per request
 */
`timescale 1ns/100ps
`include "legalizer_macros.svh"

module burst_legalizer import legalizer_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    // 1D transfer in
    input  xfer_req_t  req_i,
    input  logic       valid_i,
    output logic       ready_o,
    // read bursts
    output burst_req_t r_req_o,
    output logic       r_valid_o,
    input  logic       r_ready_i,
    // write bursts
    output burst_req_t w_req_o,
    output logic       w_valid_o,
    input  logic       w_ready_i,
    output logic       w_last_o,
    // control
    input  logic       flush_i,
    input  logic       kill_i,
    output logic       r_busy_o,
    output logic       w_busy_o
);

    xfer_opt_t                  opt_q;
    logic [`LGZ_ADDR_WIDTH-1:0] r_addr;
    logic [`LGZ_ADDR_WIDTH-1:0] w_addr;
    page_len_t                  r_bytes_to_pb;
    page_len_t                  w_bytes_to_pb;
    page_len_t                  r_bytes_possible;
    page_len_t                  w_bytes_possible;
    logic                       r_done;
    logic                       w_done;
    logic                       load;
    logic                       r_advance;
    logic                       w_advance;

    // ------------------------------
    // control
    // ------------------------------
    legalizer_control u_ctrl (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .req_i              (req_i),
        .valid_i            (valid_i),
        .ready_o            (ready_o),
        .r_ready_i          (r_ready_i),
        .w_ready_i          (w_ready_i),
        .flush_i            (flush_i),
        .kill_i             (kill_i),
        .r_done_i           (r_done),
        .w_done_i           (w_done),
        .r_busy_i           (r_busy_o),
        .w_busy_i           (w_busy_o),
        .r_bytes_to_pb_i    (r_bytes_to_pb),
        .w_bytes_to_pb_i    (w_bytes_to_pb),
        .opt_o              (opt_q),
        .r_bytes_possible_o (r_bytes_possible),
        .w_bytes_possible_o (w_bytes_possible),
        .load_o             (load),
        .r_advance_o        (r_advance),
        .w_advance_o        (w_advance),
        .r_valid_o          (r_valid_o),
        .w_valid_o          (w_valid_o)
    );

    // ------------------------------
    // read side (source)
    // ------------------------------
    page_boundary u_r_pb (
        .addr_i        (r_addr),
        .reduce_len_i  (opt_q.src_reduce_len),
        .max_llen_i    (opt_q.src_max_llen),
        .bytes_to_pb_o (r_bytes_to_pb)
    );

    burst_chopper u_r_chop (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .load_i           (load),
        .load_addr_i      (req_i.src_addr),
        .load_len_i       (req_i.length),
        .advance_i        (r_advance),
        .kill_i           (kill_i),
        .bytes_possible_i (r_bytes_possible),
        .state_addr_o     (r_addr),
        .busy_o           (r_busy_o),
        .done_o           (r_done),
        .burst_o          (r_req_o)
    );

    // ------------------------------
    // write side (destination)
    // ------------------------------
    page_boundary u_w_pb (
        .addr_i        (w_addr),
        .reduce_len_i  (opt_q.dst_reduce_len),
        .max_llen_i    (opt_q.dst_max_llen),
        .bytes_to_pb_o (w_bytes_to_pb)
    );

    burst_chopper u_w_chop (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .load_i           (load),
        .load_addr_i      (req_i.dst_addr),
        .load_len_i       (req_i.length),
        .advance_i        (w_advance),
        .kill_i           (kill_i),
        .bytes_possible_i (w_bytes_possible),
        .state_addr_o     (w_addr),
        .busy_o           (w_busy_o),
        .done_o           (w_done),
        .burst_o          (w_req_o)
    );

    // final write burst of the transfer
    assign w_last_o = w_done;

endmodule

//--- test/burst_legalizer_props.sv
/*
 * legalizer flow control properties
 * valid qualification, coupled lock step and kill
 * clearing, bound into the legalizer control
 */
`timescale 1ns/100ps

module burst_legalizer_props import legalizer_pkg::*; (
    input logic      clk_i,
    input logic      rst_i,
    input logic      flush_i,
    input logic      kill_i,
    input logic      r_ready_i,
    input logic      w_ready_i,
    input logic      r_busy_i,
    input logic      w_busy_i,
    input logic      r_valid_i,
    input logic      w_valid_i,
    input logic      load_i,
    input xfer_opt_t opt_i
);

    // read back by the testbench at the end of the run
    int fail_count;

    initial fail_count = 0;

    // ------------------------------
    // valid qualification
    // ------------------------------
    r_valid_qual: assert property (@(posedge clk_i) disable iff (rst_i)
        r_valid_i |-> r_busy_i && r_ready_i && !flush_i)
        else begin
            $error("read valid while idle, stalled or flushed");
            fail_count++;
        end

    w_valid_qual: assert property (@(posedge clk_i) disable iff (rst_i)
        w_valid_i |-> w_busy_i && w_ready_i && !flush_i)
        else begin
            $error("write valid while idle, stalled or flushed");
            fail_count++;
        end

    // coupled sides offer their bursts together
    coupled_valids: assert property (@(posedge clk_i) disable iff (rst_i)
        !opt_i.decouple_rw |-> r_valid_i == w_valid_i)
        else begin
            $error("coupled read and write valids differ");
            fail_count++;
        end

    // ------------------------------
    // kill
    // ------------------------------
    kill_clears: assert property (@(posedge clk_i) disable iff (rst_i)
        kill_i && !load_i |=> !r_busy_i && !w_busy_i)
        else begin
            $error("side still busy after kill");
            fail_count++;
        end

endmodule

bind legalizer_control burst_legalizer_props u_props (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .flush_i   (flush_i),
    .kill_i    (kill_i),
    .r_ready_i (r_ready_i),
    .w_ready_i (w_ready_i),
    .r_busy_i  (r_busy_i),
    .w_busy_i  (w_busy_i),
    .r_valid_i (r_valid_o),
    .w_valid_i (w_valid_o),
    .load_i    (load_o),
    .opt_i     (opt_q)
);

//--- test/tb_burst_legalizer.sv
/*
 * testbench for the AXI4 burst legalizer
 * applies a table of 1D transfers under steady, stalled,
 * flushed and killed flow control and checks every read
 * and write burst against a page split computed here
 */
`timescale 1ns/100ps
`include "legalizer_macros.svh"

module tb_burst_legalizer
    import legalizer_pkg::*;
();

    localparam int NUM_TESTS = 11;

    // flow control patterns per table entry
    localparam logic [1:0] MODE_STEADY = 2'd0;
    localparam logic [1:0] MODE_STALL  = 2'd1;
    localparam logic [1:0] MODE_FLUSH  = 2'd2;

    typedef struct packed {
        xfer_req_t  req;
        logic [1:0] mode;
        // cycle after acceptance that carries kill, 0 for none
        logic [7:0] kill_at;
        // bursts expected to appear on each side
        logic [7:0] r_cnt;
        logic [7:0] w_cnt;
    } test_entry_t;

    logic        clk_i;
    logic        rst_i;
    xfer_req_t   req_i;
    logic        valid_i;
    logic        ready_o;
    burst_req_t  r_req_o;
    logic        r_valid_o;
    logic        r_ready_i;
    burst_req_t  w_req_o;
    logic        w_valid_o;
    logic        w_ready_i;
    logic        w_last_o;
    logic        flush_i;
    logic        kill_i;
    logic        r_busy_o;
    logic        w_busy_o;

    test_entry_t tests [NUM_TESTS];
    // reference bursts of the running entry
    burst_req_t  want_r [$];
    burst_req_t  want_w [$];
    integer      seed;
    int          errors;
    int          checks;
    int          failed_tests;

    // ------------------------------
    // clock and DUT
    // ------------------------------
    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    burst_legalizer burst_legalizer_i (.*);

    // ------------------------------
    // reference model
    // ------------------------------
    // page in bytes, 2^(offset + llen) when reduced, 256 beats otherwise
    function automatic int page_bytes(logic reduce, logic [`LGZ_LLEN_WIDTH-1:0] llen);
        int width;
        width = `LGZ_OFFSET_WIDTH + (reduce ? int'(llen) : 8);
        if (width > `LGZ_PAGE_ADDR_WIDTH) begin
            width = `LGZ_PAGE_ADDR_WIDTH;
        end
        return 1 << width;
    endfunction

    function automatic int room_left(logic [31:0] addr, int page);
        return page - int'(addr % page);
    endfunction

    // beats touched by nbytes from addr, partial beats round up
    function automatic burst_req_t beat_burst(logic [31:0] addr, int nbytes);
        burst_req_t b;
        int         beats;
        beats  = (int'(addr % `LGZ_STRB_WIDTH) + nbytes + `LGZ_STRB_WIDTH - 1)
                 / `LGZ_STRB_WIDTH;
        b.addr = addr - (addr % `LGZ_STRB_WIDTH);
        b.len  = 8'(beats - 1);
        return b;
    endfunction

    task automatic build_expected(input xfer_req_t req);
        logic [31:0] ra;
        logic [31:0] wa;
        int          rem_r;
        int          rem_w;
        int          page_r;
        int          page_w;
        int          n;
        want_r.delete();
        want_w.delete();
        ra     = req.src_addr;
        wa     = req.dst_addr;
        rem_r  = req.length;
        rem_w  = req.length;
        page_r = page_bytes(req.opt.src_reduce_len, req.opt.src_max_llen);
        page_w = page_bytes(req.opt.dst_reduce_len, req.opt.dst_max_llen);
        if (req.opt.decouple_rw) begin
            // each side walks its own pages
            while (rem_r > 0) begin
                n = (rem_r < room_left(ra, page_r)) ? rem_r : room_left(ra, page_r);
                want_r.push_back(beat_burst(ra, n));
                ra    += n;
                rem_r -= n;
            end
            while (rem_w > 0) begin
                n = (rem_w < room_left(wa, page_w)) ? rem_w : room_left(wa, page_w);
                want_w.push_back(beat_burst(wa, n));
                wa    += n;
                rem_w -= n;
            end
        end else begin
            // one cut for both, at the nearer boundary
            while (rem_r > 0) begin
                n = room_left(ra, page_r);
                if (room_left(wa, page_w) < n) begin
                    n = room_left(wa, page_w);
                end
                if (rem_r < n) begin
                    n = rem_r;
                end
                want_r.push_back(beat_burst(ra, n));
                want_w.push_back(beat_burst(wa, n));
                ra    += n;
                wa    += n;
                rem_r -= n;
            end
        end
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic compare_burst(string name, burst_req_t got, burst_req_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0t ns: %s got addr %h len %0d, expected addr %h len %0d",
                     $time, name, got.addr, got.len, want.addr, want.len);
        end
    endtask

    task automatic compare_bit(string name, logic got, logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0t ns: %s got %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic compare_count(string name, int got, int want);
        checks++;
        if (got != want) begin
            errors++;
            $display("FAILED at %0t ns: %s got %0d, expected %0d", $time, name, got, want);
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    function automatic test_entry_t make_entry(
        logic [31:0] len, logic [31:0] src, logic [31:0] dst, logic [8:0] opt,
        logic [1:0] mode, logic [7:0] kill_at, logic [7:0] r_cnt, logic [7:0] w_cnt);
        test_entry_t e;
        e.req.length   = len;
        e.req.src_addr = src;
        e.req.dst_addr = dst;
        e.req.opt      = xfer_opt_t'(opt);
        e.mode         = mode;
        e.kill_at      = kill_at;
        e.r_cnt        = r_cnt;
        e.w_cnt        = w_cnt;
        return e;
    endfunction

    // opt is decouple, then src and dst nibbles of reduce and llen
    task automatic fill_table();
        tests[0]  = make_entry(64, 32'h0000_1000, 32'h0000_2000, {1'b0, 4'h0, 4'h0},
                               MODE_STEADY, 0, 1, 1);
        tests[1]  = make_entry(3000, 32'h0000_0300, 32'h0001_0100, {1'b1, 4'h0, 4'h0},
                               MODE_STEADY, 0, 4, 4);
        tests[2]  = make_entry(256, 32'h0000_4000, 32'h0000_5000, {1'b1, 4'hC, 4'h0},
                               MODE_STEADY, 0, 4, 1);
        tests[3]  = make_entry(2048, 32'h0000_0200, 32'h0000_3300, {1'b0, 4'h0, 4'h0},
                               MODE_STEADY, 0, 5, 5);
        tests[4]  = make_entry(1001, 32'h0000_0FF3, 32'h0000_2005, {1'b0, 4'h0, 4'h0},
                               MODE_STALL, 0, 2, 2);
        tests[5]  = make_entry(200, 32'h0000_6010, 32'h0000_7008, {1'b1, 4'h0, 4'hB},
                               MODE_FLUSH, 0, 1, 7);
        tests[6]  = make_entry(4096, 32'h0001_0000, 32'h0002_0000, {1'b0, 4'h0, 4'h0},
                               MODE_FLUSH, 0, 4, 4);
        // killed mid transfer, only the bursts before the kill show up
        tests[7]  = make_entry(4096, 32'h0003_0000, 32'h0004_0000, {1'b0, 4'h0, 4'h0},
                               MODE_STEADY, 2, 2, 2);
        tests[8]  = make_entry(100, 32'h0005_0002, 32'h0006_0001, {1'b1, 4'h0, 4'h0},
                               MODE_STALL, 0, 1, 1);
        tests[9]  = make_entry(128, 32'h0007_0000, 32'h0007_8000, {1'b1, 4'hA, 4'h0},
                               MODE_STEADY, 3, 3, 1);
        tests[10] = make_entry(1024, 32'h0008_0000, 32'h0009_0000, {1'b0, 4'h0, 4'hF},
                               MODE_STALL, 0, 2, 2);
    endtask

    // readies, flush and kill for one cycle
    task automatic drive_flow(test_entry_t t, bit accepted, int cyc);
        if (t.mode == MODE_STEADY) begin
            r_ready_i = 1'b1;
            w_ready_i = 1'b1;
        end else begin
            r_ready_i = (($random(seed) & 3) != 0);
            w_ready_i = (($random(seed) & 3) != 0);
        end
        flush_i = 1'b0;
        kill_i  = 1'b0;
        if (accepted && t.mode == MODE_FLUSH && (cyc % 3) == 1) begin
            flush_i = 1'b1;
        end
        // flush with kill keeps the kill cycle free of bursts
        if (accepted && t.kill_at != 0 && cyc == t.kill_at) begin
            flush_i = 1'b1;
            kill_i  = 1'b1;
        end
    endtask

    task automatic run_test(int idx);
        test_entry_t t;
        bit          accepted;
        bit          take;
        bit          finished;
        logic        exp_valid;
        int          cyc;
        int          r_seen;
        int          w_seen;
        int          err_before;
        t          = tests[idx];
        err_before = errors;
        build_expected(t.req);
        accepted = 0;
        finished = 0;
        cyc      = 0;
        r_seen   = 0;
        w_seen   = 0;
        @(posedge clk_i);
        #1;
        req_i   = t.req;
        valid_i = 1'b1;
        drive_flow(t, 1'b0, 0);
        while (!finished) begin
            // outputs settled half a cycle after the inputs moved
            @(negedge clk_i);
            if (flush_i) begin
                compare_bit("r_valid_o", r_valid_o, 1'b0);
                compare_bit("w_valid_o", w_valid_o, 1'b0);
            end
            if (accepted && t.kill_at != 0 && cyc == t.kill_at + 1) begin
                compare_bit("r_busy_o", r_busy_o, 1'b0);
                compare_bit("w_busy_o", w_busy_o, 1'b0);
            end
            if (accepted && !t.req.opt.decouple_rw) begin
                // lock step, both sides offer a burst while one is left and both readies are up
                exp_valid = (r_seen < t.r_cnt) && r_ready_i && w_ready_i && !flush_i;
                compare_bit("r_valid_o", r_valid_o, exp_valid);
                compare_bit("w_valid_o", w_valid_o, exp_valid);
            end
            if (accepted && r_valid_o) begin
                if (r_seen < want_r.size()) begin
                    compare_burst("r_req_o", r_req_o, want_r[r_seen]);
                end
                r_seen++;
            end
            if (accepted && w_valid_o) begin
                if (w_seen < want_w.size()) begin
                    compare_burst("w_req_o", w_req_o, want_w[w_seen]);
                    compare_bit("w_last_o", w_last_o, w_seen == want_w.size() - 1);
                end
                w_seen++;
            end
            if (accepted && !r_busy_o && !w_busy_o) begin
                finished = 1;
            end
            take = ready_o && valid_i;
            if (!finished) begin
                @(posedge clk_i);
                #1;
                if (accepted) begin
                    cyc++;
                end
                if (take) begin
                    accepted = 1;
                    valid_i  = 1'b0;
                end
                drive_flow(t, accepted, cyc);
            end
        end
        compare_count("read burst count", r_seen, t.r_cnt);
        compare_count("write burst count", w_seen, t.w_cnt);
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("test %0d: %s, %0d read and %0d write bursts", idx,
                 (errors == err_before) ? "ok" : "mismatch", r_seen, w_seen);
    endtask

    task automatic check_reset_state();
        @(negedge clk_i);
        compare_bit("r_busy_o", r_busy_o, 1'b0);
        compare_bit("w_busy_o", w_busy_o, 1'b0);
        @(posedge clk_i);
        #1;
        r_ready_i = 1'b1;
        w_ready_i = 1'b1;
        // readies up, so only an idle side keeps valid low
        @(negedge clk_i);
        compare_bit("r_valid_o", r_valid_o, 1'b0);
        compare_bit("w_valid_o", w_valid_o, 1'b0);
        compare_bit("ready_o", ready_o, 1'b1);
        $display("reset state: %s", (errors == 0) ? "ok" : "mismatch");
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        seed         = 32'h3b16c5b4;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        rst_i        = 1'b1;
        req_i        = '0;
        valid_i      = 1'b0;
        r_ready_i    = 1'b0;
        w_ready_i    = 1'b0;
        flush_i      = 1'b0;
        kill_i       = 1'b0;
        fill_table();
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_reset_state();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        // bound flow control properties count their own failures
        errors += burst_legalizer_i.u_ctrl.u_props.fail_count;
        $display("%0d tests, %0d failed, %0d checks, %0d errors", NUM_TESTS, failed_tests,
                 checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog, about 2 us per table entry
    initial begin
        #(NUM_TESTS * 2000);
        $display("timeout after %0d ns, the tests did not finish", NUM_TESTS * 2000);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- all.f
+incdir+include
hw/legalizer_pkg.sv
hw/page_boundary.sv
hw/burst_chopper.sv
hw/legalizer_control.sv
hw/burst_legalizer.sv
test/burst_legalizer_props.sv
test/tb_burst_legalizer.sv
